//--- src/zmips_pkg.sv
// Shared widths and encodings for the integer-only core with no branch, jump or flag support
package zmips_pkg;

    localparam int XLEN = 32;                   // Data and address width

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;        // 32 registers, r0 reads as zero

    // I-format opcodes
    localparam logic [5:0] OP_SUBI = 6'h10;     // rt = rs - se_imm
    localparam logic [5:0] OP_ADDI = 6'h11;     // rt = rs + se_imm
    localparam logic [5:0] OP_LW   = 6'h16;     // rt = mem[rs + se_imm]
    localparam logic [5:0] OP_SW   = 6'h17;     // mem[rs + se_imm] = rt

    // R-format op field has bits 5..4 clear
    // Bit 2 enables write back to rd and bits 1..0 pick the pre-shift of A

    // ALU operation, taken from funct[5:3] on R-format
    typedef logic [2:0] alu_op_t;
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;         // Codes 5..7 pass A through

    // Pre-shift applied to ALU input A
    typedef logic [1:0] shift_op_t;
    localparam shift_op_t SH_NONE = 2'd0;
    localparam shift_op_t SH_SLL  = 2'd1;
    localparam shift_op_t SH_SRL  = 2'd2;
    localparam shift_op_t SH_SRA  = 2'd3;

    typedef struct packed {
        logic [5:0] op;
        reg_addr_t  rs;                         // Source A, may be pre-shifted
        reg_addr_t  rt;                         // Source B
        reg_addr_t  rd;                         // Destination
        logic [4:0] shamt;                      // Pre-shift amount
        logic [5:0] funct;                      // ALU op in bits 5..3
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        reg_addr_t   rs;                        // Base or source
        reg_addr_t   rt;                        // Destination, or store data for SW
        logic [15:0] imm;                       // Sign-extended in decode
    } i_fmt_t;

    // Same fetched word seen either way
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_t;

endpackage

//--- src/zmips_fetch.sv
// PC steps by 4 only since there are no branches, and the instruction memory must answer in the same cycle
`timescale 1ns/1ns

module zmips_fetch #(
    parameter zmips_pkg::word_t RESET_PC = '0
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,            // Load-use hold from decode
    output zmips_pkg::word_t  i_addr,
    input  zmips_pkg::word_t  i_data,
    output zmips_pkg::instr_t instr             // IF/ID register
);

    zmips_pkg::word_t pc;

    assign i_addr = pc;                         // Combinational instruction fetch

    // PC and IF/ID freeze together so the stalled word is decoded again
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc    <= RESET_PC;
            instr <= '0;                        // All-zero word is an R-format op without write back
        end
        else if (!stall)
        begin
            pc    <= pc + zmips_pkg::word_t'(4);
            instr <= i_data;
        end
    end

endmodule

//--- src/zmips_regfile.sv
// Register 0 is hardwired to zero and a write in the same cycle is bypassed to both read ports
`timescale 1ns/1ns

module zmips_regfile (
    input  logic                 clk,
    input  logic                 rst,
    input  zmips_pkg::reg_addr_t rd_addr_0,
    input  zmips_pkg::reg_addr_t rd_addr_1,
    output zmips_pkg::word_t     rd_data_0,
    output zmips_pkg::word_t     rd_data_1,
    input  zmips_pkg::reg_addr_t wr_addr,
    input  zmips_pkg::word_t     wr_data,
    input  logic                 wr
);

    zmips_pkg::word_t regs [32];

    always_ff @(posedge clk)
    begin
        if (wr && wr_addr != '0)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Read ports see the value being written back this cycle
    always_comb
    begin
        if (rd_addr_0 == '0)
            rd_data_0 = '0;
        else if (wr && wr_addr == rd_addr_0)
            rd_data_0 = wr_data;                // Write-through
        else
            rd_data_0 = regs[rd_addr_0];

        if (rd_addr_1 == '0)
            rd_data_1 = '0;
        else if (wr && wr_addr == rd_addr_1)
            rd_data_1 = wr_data;
        else
            rd_data_1 = regs[rd_addr_1];
    end

    // Decode drops the write enable for r0, so no write can reach it from the pipe
    a_no_r0_write: assert property (@(posedge clk) disable iff (rst) wr |-> wr_addr != '0);

endmodule

//--- src/zmips_decode.sv
// Undefined opcodes decode as NOP, and SW store data is not checked for load-use since memory forwards it
`timescale 1ns/1ns

module zmips_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  zmips_pkg::instr_t      instr,       // From IF/ID
    input  logic                   ex_mem_rd,   // Load now in execute
    input  zmips_pkg::reg_addr_t   ex_dst,
    input  zmips_pkg::word_t       wb_data,
    input  zmips_pkg::reg_addr_t   wb_dst,
    input  logic                   wb_wr,
    output logic                   stall,
    output zmips_pkg::word_t       rs_val,      // ID/EX register from here down
    output zmips_pkg::word_t       rt_val,
    output zmips_pkg::reg_addr_t   rs,
    output zmips_pkg::reg_addr_t   rt,
    output zmips_pkg::reg_addr_t   dst,
    output zmips_pkg::word_t       imm,
    output zmips_pkg::alu_op_t     alu_op,
    output zmips_pkg::shift_op_t   shift_op,
    output logic [4:0]             shamt,
    output logic                   use_imm,
    output logic                   mem_rd,
    output logic                   mem_wr,
    output logic                   wr_reg
);

    logic [5:0]           op;
    logic                 r_fmt;
    zmips_pkg::word_t     rf_rs_val;
    zmips_pkg::word_t     rf_rt_val;
    zmips_pkg::reg_addr_t d_dst;
    zmips_pkg::alu_op_t   d_alu_op;
    logic                 d_use_imm;
    logic                 d_mem_rd;
    logic                 d_mem_wr;
    logic                 d_wr_reg;
    logic                 uses_rt;

    assign op    = instr.r.op;
    assign r_fmt = (op[5:4] == 2'b00);
    assign d_dst = r_fmt ? instr.r.rd : instr.i.rt;

    zmips_regfile u_regfile (
        .clk       (clk),
        .rst       (rst),
        .rd_addr_0 (instr.r.rs),
        .rd_addr_1 (instr.r.rt),
        .rd_data_0 (rf_rs_val),
        .rd_data_1 (rf_rt_val),
        .wr_addr   (wb_dst),
        .wr_data   (wb_data),
        .wr        (wb_wr)
    );

    // Opcode to control bits
    always_comb
    begin
        d_alu_op  = instr.r.funct[5:3];
        d_use_imm = 1'b0;
        d_mem_rd  = 1'b0;
        d_mem_wr  = 1'b0;
        d_wr_reg  = 1'b0;
        if (r_fmt)
        begin
            d_wr_reg = op[2];                   // Write back only with bit 2 set
        end
        else
        begin
            case (op)
                zmips_pkg::OP_ADDI, zmips_pkg::OP_LW:
                begin
                    d_alu_op  = zmips_pkg::ALU_ADD;
                    d_use_imm = 1'b1;
                    d_wr_reg  = 1'b1;
                    d_mem_rd  = (op == zmips_pkg::OP_LW);
                end
                zmips_pkg::OP_SUBI:
                begin
                    d_alu_op  = zmips_pkg::ALU_SUB;
                    d_use_imm = 1'b1;
                    d_wr_reg  = 1'b1;
                end
                zmips_pkg::OP_SW:
                begin
                    d_alu_op  = zmips_pkg::ALU_ADD;   // Address only, no write back
                    d_use_imm = 1'b1;
                    d_mem_wr  = 1'b1;
                end
                default:
                begin
                    d_alu_op = zmips_pkg::ALU_ADD;    // NOP
                end
            endcase
        end
        if (d_dst == '0)
            d_wr_reg = 1'b0;                    // r0 never written and so never forwarded
    end

    // Load in execute feeding rs, or rt of an R-format op, needs one bubble
    assign uses_rt = r_fmt;
    assign stall   = ex_mem_rd && ex_dst != '0
                     && ((r_fmt || d_use_imm) && ex_dst == instr.r.rs
                         || uses_rt && ex_dst == instr.r.rt);

    always_ff @(posedge clk)
    begin
        rs_val   <= rf_rs_val;
        rt_val   <= rf_rt_val;
        rs       <= instr.r.rs;
        rt       <= instr.r.rt;
        dst      <= d_dst;
        imm      <= {{(zmips_pkg::XLEN - 16){instr.i.imm[15]}}, instr.i.imm};
        alu_op   <= d_alu_op;
        shift_op <= r_fmt ? instr.r.op[1:0] : zmips_pkg::SH_NONE;
        shamt    <= instr.r.shamt;
        use_imm  <= d_use_imm;
        if (rst || stall)
        begin
            mem_rd <= 1'b0;                     // Bubble into ID/EX
            mem_wr <= 1'b0;
            wr_reg <= 1'b0;
        end
        else
        begin
            mem_rd <= d_mem_rd;
            mem_wr <= d_mem_wr;
            wr_reg <= d_wr_reg;
        end
    end

    // The bubble clears mem_rd in execute, so a stall never repeats
    a_single_stall: assert property (@(posedge clk) disable iff (rst) stall |=> !stall);

endmodule

//--- src/zmips_execute.sv
// Forwards from EX/MEM and MEM/WB only, a load in EX/MEM is not forwarded since decode stalls for it
`timescale 1ns/1ns

module zmips_execute (
    input  logic                 clk,
    input  logic                 rst,
    input  zmips_pkg::word_t     rs_val,        // ID/EX register
    input  zmips_pkg::word_t     rt_val,
    input  zmips_pkg::reg_addr_t rs,
    input  zmips_pkg::reg_addr_t rt,
    input  zmips_pkg::reg_addr_t dst,
    input  zmips_pkg::word_t     imm,
    input  zmips_pkg::alu_op_t   alu_op,
    input  zmips_pkg::shift_op_t shift_op,
    input  logic [4:0]           shamt,
    input  logic                 use_imm,
    input  logic                 mem_rd,
    input  logic                 mem_wr,
    input  logic                 wr_reg,
    input  zmips_pkg::word_t     wb_data,       // MEM/WB forward
    input  zmips_pkg::reg_addr_t wb_dst,
    input  logic                 wb_wr,
    output logic                 ex_mem_rd,     // Hazard check in decode
    output zmips_pkg::reg_addr_t ex_dst,
    output zmips_pkg::word_t     alu_rslt,      // EX/MEM register
    output zmips_pkg::word_t     st_data,
    output zmips_pkg::reg_addr_t em_dst,
    output logic                 em_mem_rd,
    output logic                 em_mem_wr,
    output logic                 em_wr_reg
);

    zmips_pkg::word_t fwd_a;
    zmips_pkg::word_t fwd_b;
    zmips_pkg::word_t alu_a;
    zmips_pkg::word_t alu_b;
    zmips_pkg::word_t alu_y;
    logic             em_fwd_ok;

    assign ex_mem_rd = mem_rd;
    assign ex_dst    = dst;

    assign em_fwd_ok = em_wr_reg && !em_mem_rd;   // EX/MEM holds an ALU result

    // Newest value first
    always_comb
    begin
        if (em_fwd_ok && em_dst == rs)
            fwd_a = alu_rslt;
        else if (wb_wr && wb_dst == rs)
            fwd_a = wb_data;
        else
            fwd_a = rs_val;

        if (em_fwd_ok && em_dst == rt)
            fwd_b = alu_rslt;
        else if (wb_wr && wb_dst == rt)
            fwd_b = wb_data;
        else
            fwd_b = rt_val;
    end

    // Barrel pre-shift of A
    always_comb
    begin
        case (shift_op)
            zmips_pkg::SH_SLL: alu_a = fwd_a << shamt;
            zmips_pkg::SH_SRL: alu_a = fwd_a >> shamt;
            zmips_pkg::SH_SRA: alu_a = $signed(fwd_a) >>> shamt;
            default:           alu_a = fwd_a;
        endcase
    end

    assign alu_b = use_imm ? imm : fwd_b;

    always_comb
    begin
        case (alu_op)
            zmips_pkg::ALU_ADD: alu_y = alu_a + alu_b;
            zmips_pkg::ALU_SUB: alu_y = alu_a - alu_b;
            zmips_pkg::ALU_AND: alu_y = alu_a & alu_b;
            zmips_pkg::ALU_OR:  alu_y = alu_a | alu_b;
            zmips_pkg::ALU_XOR: alu_y = alu_a ^ alu_b;
            default:            alu_y = alu_a;  // Pass A
        endcase
    end

    always_ff @(posedge clk)
    begin
        alu_rslt <= alu_y;                      // Also the data address
        st_data  <= fwd_b;                      // Store data before the immediate mux
        em_dst   <= dst;
        if (rst)
        begin
            em_mem_rd <= 1'b0;
            em_mem_wr <= 1'b0;
            em_wr_reg <= 1'b0;
        end
        else
        begin
            em_mem_rd <= mem_rd;
            em_mem_wr <= mem_wr;
            em_wr_reg <= wr_reg;
        end
    end

    // Opcode decode keeps the two strobes exclusive
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(em_mem_rd && em_mem_wr));

endmodule

//--- src/zmips_mem_wb.sv
// Data memory must be zero-wait, so load data is taken in the same cycle as d_rd
`timescale 1ns/1ns

module zmips_mem_wb (
    input  logic                 clk,
    input  logic                 rst,
    input  zmips_pkg::word_t     alu_rslt,      // EX/MEM register
    input  zmips_pkg::word_t     st_data,
    input  zmips_pkg::reg_addr_t dst,
    input  logic                 mem_rd,
    input  logic                 mem_wr,
    input  logic                 wr_reg,
    output zmips_pkg::word_t     d_addr,
    output zmips_pkg::word_t     d_data_o,
    output logic                 d_rd,
    output logic                 d_wr,
    input  zmips_pkg::word_t     d_data_i,
    output zmips_pkg::word_t     wb_data,
    output zmips_pkg::reg_addr_t wb_dst,
    output logic                 wb_wr
);

    zmips_pkg::word_t mem_data;                 // MEM/WB loaded word
    zmips_pkg::word_t alu_data;                 // MEM/WB ALU word
    logic             wb_ld;                    // MEM/WB holds a load
    logic             ld_fwd;

    // SW right after an LW of its data register takes the loaded word
    // For SW, dst is its rt field
    assign ld_fwd = mem_wr && wb_ld && wb_wr && wb_dst == dst;

    assign d_addr   = alu_rslt;
    assign d_data_o = ld_fwd ? mem_data : st_data;
    assign d_rd     = mem_rd;
    assign d_wr     = mem_wr;

    always_ff @(posedge clk)
    begin
        mem_data <= d_data_i;
        alu_data <= alu_rslt;
        wb_dst   <= dst;
        if (rst)
        begin
            wb_ld <= 1'b0;
            wb_wr <= 1'b0;
        end
        else
        begin
            wb_ld <= mem_rd;
            wb_wr <= wr_reg;
        end
    end

    assign wb_data = wb_ld ? mem_data : alu_data;   // Write-back select

endmodule

//--- src/zmips.sv
// Five-stage core with external zero-wait memories and no back-pressure or branch support
`timescale 1ns/1ns

module zmips #(
    parameter zmips_pkg::word_t RESET_PC = '0
) (
    input  logic             clk,
    input  logic             rst,               // Synchronous, active high
    output zmips_pkg::word_t i_addr,
    input  zmips_pkg::word_t i_data,
    output zmips_pkg::word_t d_addr,
    output zmips_pkg::word_t d_data_o,
    input  zmips_pkg::word_t d_data_i,
    output logic             d_rd,
    output logic             d_wr
);

    zmips_pkg::instr_t    instr;
    logic                 stall;
    zmips_pkg::word_t     rs_val;
    zmips_pkg::word_t     rt_val;
    zmips_pkg::reg_addr_t rs;
    zmips_pkg::reg_addr_t rt;
    zmips_pkg::reg_addr_t dst;
    zmips_pkg::word_t     imm;
    zmips_pkg::alu_op_t   alu_op;
    zmips_pkg::shift_op_t shift_op;
    logic [4:0]           shamt;
    logic                 use_imm;
    logic                 mem_rd;
    logic                 mem_wr;
    logic                 wr_reg;
    logic                 ex_mem_rd;
    zmips_pkg::reg_addr_t ex_dst;
    zmips_pkg::word_t     alu_rslt;
    zmips_pkg::word_t     st_data;
    zmips_pkg::reg_addr_t em_dst;
    logic                 em_mem_rd;
    logic                 em_mem_wr;
    logic                 em_wr_reg;
    zmips_pkg::word_t     wb_data;
    zmips_pkg::reg_addr_t wb_dst;
    logic                 wb_wr;

    zmips_fetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .i_addr (i_addr),
        .i_data (i_data),
        .instr  (instr)
    );

    zmips_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .ex_mem_rd (ex_mem_rd),
        .ex_dst    (ex_dst),
        .wb_data   (wb_data),
        .wb_dst    (wb_dst),
        .wb_wr     (wb_wr),
        .stall     (stall),
        .rs_val    (rs_val),
        .rt_val    (rt_val),
        .rs        (rs),
        .rt        (rt),
        .dst       (dst),
        .imm       (imm),
        .alu_op    (alu_op),
        .shift_op  (shift_op),
        .shamt     (shamt),
        .use_imm   (use_imm),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .wr_reg    (wr_reg)
    );

    zmips_execute u_execute (
        .clk       (clk),
        .rst       (rst),
        .rs_val    (rs_val),
        .rt_val    (rt_val),
        .rs        (rs),
        .rt        (rt),
        .dst       (dst),
        .imm       (imm),
        .alu_op    (alu_op),
        .shift_op  (shift_op),
        .shamt     (shamt),
        .use_imm   (use_imm),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .wr_reg    (wr_reg),
        .wb_data   (wb_data),
        .wb_dst    (wb_dst),
        .wb_wr     (wb_wr),
        .ex_mem_rd (ex_mem_rd),
        .ex_dst    (ex_dst),
        .alu_rslt  (alu_rslt),
        .st_data   (st_data),
        .em_dst    (em_dst),
        .em_mem_rd (em_mem_rd),
        .em_mem_wr (em_mem_wr),
        .em_wr_reg (em_wr_reg)
    );

    zmips_mem_wb u_mem_wb (
        .clk      (clk),
        .rst      (rst),
        .alu_rslt (alu_rslt),
        .st_data  (st_data),
        .dst      (em_dst),
        .mem_rd   (em_mem_rd),
        .mem_wr   (em_mem_wr),
        .wr_reg   (em_wr_reg),
        .d_addr   (d_addr),
        .d_data_o (d_data_o),
        .d_rd     (d_rd),
        .d_wr     (d_wr),
        .d_data_i (d_data_i),
        .wb_data  (wb_data),
        .wb_dst   (wb_dst),
        .wb_wr    (wb_wr)
    );

endmodule

//--- tb/tb_zmips.sv
// Assumes RESET_PC 0 and a program image in tb/program_input.hex whose stores are checked in order
`timescale 1ns/1ns

module tb_zmips;

    localparam zmips_pkg::word_t RESET_PC = '0;
    localparam int PROG_WORDS = 64;                     // Program area of the image
    localparam int CNT_IDX    = 64;                     // Expected store count
    localparam int TIMEOUT_NS = (64 + 8 + 20) * 10 * 2;

    logic             clk;
    logic             rst;
    zmips_pkg::word_t i_addr;
    zmips_pkg::word_t i_data;
    zmips_pkg::word_t d_addr;
    zmips_pkg::word_t d_data_o;
    zmips_pkg::word_t d_data_i;
    logic             d_rd;
    logic             d_wr;

    zmips_pkg::word_t image [0:127];                    // Program words followed by count and pairs
    zmips_pkg::word_t dmem [0:63];
    int               errors;
    int               tests;
    int               n_exp;
    int               st_idx;

    zmips #(
        .RESET_PC (RESET_PC)
    ) DUT (
        .clk      (clk),
        .rst      (rst),
        .i_addr   (i_addr),
        .i_data   (i_data),
        .d_addr   (d_addr),
        .d_data_o (d_data_o),
        .d_data_i (d_data_i),
        .d_rd     (d_rd),
        .d_wr     (d_wr)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Zero-wait instruction memory returns zero past the program
    always_comb
    begin
        if (i_addr < zmips_pkg::word_t'(PROG_WORDS * 4))
            i_data = image[i_addr[8:2]];
        else
            i_data = '0;
    end

    // Word-addressed data memory read with no wait states
    always_comb d_data_i = d_rd ? dmem[d_addr[7:2]] : '0;

    // Store port, whole array held at zero through reset
    always @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 64; i++)
                dmem[i] <= '0;
        end
        else if (d_wr)
        begin
            dmem[d_addr[7:2]] <= d_data_o;
        end
    end

    task automatic check_word(input string name, input zmips_pkg::word_t exp,
                              input zmips_pkg::word_t act);
        if (act !== exp)
        begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("Fail %s expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    // Ends a run that never reaches its last expected store
    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout: the program did not finish its expected stores (%0d of %0d seen)",
                 st_idx, n_exp);
        $display("ERRORS FOUND");
        $finish;
    end

    initial
    begin
        string name;

        errors = 0;
        tests  = 0;
        st_idx = 0;
        rst    = 1'b1;
        for (int i = 0; i < 128; i++)
            image[i] = '0;
        $readmemh("tb/program_input.hex", image);
        n_exp = int'(image[CNT_IDX]);

        // Strobes stay low and the PC stays parked through 8 reset cycles
        for (int i = 0; i < 8; i++)
        begin
            @(negedge clk);
            check_word("reset i_addr", RESET_PC, i_addr);
            check_bit("reset d_rd", 1'b0, d_rd);
            check_bit("reset d_wr", 1'b0, d_wr);
        end
        rst = 1'b0;
        @(negedge clk);                                 // First cycle out of reset
        check_word("first fetch i_addr", RESET_PC + zmips_pkg::word_t'(4), i_addr);
        check_bit("after reset d_rd", 1'b0, d_rd);
        check_bit("after reset d_wr", 1'b0, d_wr);
        tests++;
        $display("reset test finished");

        // Each store is one test and is compared in program order
        while (st_idx < n_exp)
        begin
            @(negedge clk);
            check_bit("strobes exclusive", 1'b0, d_rd && d_wr);
            if (d_wr)
            begin
                name = $sformatf("store %0d", st_idx);
                check_word({name, " addr"}, image[CNT_IDX + 1 + 2 * st_idx], d_addr);
                check_word({name, " data"}, image[CNT_IDX + 2 + 2 * st_idx], d_data_o);
                $display("%s finished", name);
                tests++;
                st_idx++;
            end
        end

        // Trailing NOPs must not store anything
        repeat (10)
        begin
            @(negedge clk);
            if (d_wr)
            begin
                $display("An extra store to address %h came after the expected list", d_addr);
                errors++;
            end
        end

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- compile.f
src/zmips_pkg.sv
src/zmips_fetch.sv
src/zmips_regfile.sv
src/zmips_decode.sv
src/zmips_execute.sv
src/zmips_mem_wb.sv
src/zmips.sv
tb/tb_zmips.sv

//--- Makefile
# Build the core with its testbench in Verilator and run it

LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_zmips -f compile.f -o tb_zmips
	./obj_dir/tb_zmips | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb/program_input.hex
// Words 0..63 program (unlisted words are NOP), word 64 store count
// Then one address line and one data line per expected store
44010064
4402FFFD
5C010000
5C020004
58030000
58040004
10642800
5C050008
10643008
10643810
10644018
10644820
5C06000C
5C070010
5C080014
5C090018
402AFFFB
440BFFF0
15606100
19606900
1D607100
5C0A001C
5C0C0020
5C0D0024
5C0E0028
440F0007
45F00001
45F10002
45F20003
12119800
5C13002C
5C120030
58140008
5C140034
5815000C
46B60001
5C160038
44000037
10210000
5C00003C
@40
00000010
00000000 00000064
00000004 FFFFFFFD
00000008 00000061
0000000C 00000067
00000010 00000064
00000014 FFFFFFFD
00000018 FFFFFF99
0000001C 00000069
00000020 FFFFFF00
00000024 0FFFFFFF
00000028 FFFFFFFF
0000002C 00000011
00000030 0000000A
00000034 00000061
00000038 00000068
0000003C 00000000
